// File: Makefile
# Verilator build and run of the video timing testbench
# all variables may be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_pong_video
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "log check: passed"; \
	else \
		echo "log check: pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
+incdir+src
src/pong_pkg.sv
src/video_timing_if.sv
src/hcounter.sv
src/vcounter.sv
src/sync_gen.sv
src/net_gen.sv
src/pong_video.sv
test/tb_pong_video.sv

// File: src/hcounter.sv
/* pixel counter over one line, modulo H_TOTAL, with end-of-line strobe */
`timescale 1ns/1ps
`include "pong_defines.svh"

module hcounter (
  input logic             hreset,  // pixel clock
  input logic             vreset,  // sync reset, active high
  video_timing_if.hsrc    tim
);

  localparam pong_pkg::hcount_t H_LAST = pong_pkg::hcount_t'(`H_TOTAL - 1);  // 454
  localparam pong_pkg::hcount_t H_MAX  = pong_pkg::hcount_t'(`H_TOTAL);      // 455

  pong_pkg::hcount_t hcnt_q;  // current pixel position
  logic              last;    // on last pixel of line

  assign last = (hcnt_q == H_LAST);

  always_ff @(posedge hreset) begin
    if (vreset) begin
      hcnt_q <= '0;                            // line restarts at 0
    end else if (last) begin
      hcnt_q <= '0;                            // wrap 454 -> 0
    end else begin
      hcnt_q <= hcnt_q + pong_pkg::hcount_t'(1);
    end
  end

  assign tim.hcnt     = hcnt_q;
  assign tim.line_end = last;  // one cycle per line, no handshake

  // count stays inside the line
  a_hcnt_range: assert property (
    @(posedge hreset) disable iff (vreset)
    hcnt_q < H_MAX
  );

  // strobe marks the wrap, next pixel is column 0
  a_line_wrap: assert property (
    @(posedge hreset) disable iff (vreset)
    tim.line_end |=> (tim.hcnt == '0) && !tim.line_end
  );

endmodule

// File: src/net_gen.sv
/* registered dashed centre net, the only video source, gated by blanking */
`timescale 1ns/1ps
`include "pong_defines.svh"

module net_gen (
  input  logic            hreset,  // pixel clock
  input  logic            vreset,  // sync reset, active high
  video_timing_if.sink    tim,
  output logic            video
);

  localparam pong_pkg::hcount_t NET_COL = pong_pkg::hcount_t'(`NET_COLUMN);
  localparam pong_pkg::hcount_t HB_END  = pong_pkg::hcount_t'(`HBLANK_END);
  localparam pong_pkg::vcount_t VB_END  = pong_pkg::vcount_t'(`VBLANK_END);

  logic on_column;  // pixel column of the net
  logic on_dash;    // v4 set on dash lines
  logic visible;    // outside both blanking ranges

  assign on_column = (tim.hcnt == NET_COL);
  assign on_dash   = tim.vcnt[`NET_DASH_BIT];
  assign visible   = (tim.hcnt >= HB_END) && (tim.vcnt >= VB_END);

  // same latency as blank so the two line up
  always_ff @(posedge hreset) begin
    if (vreset) begin
      video <= 1'b0;
    end else begin
      video <= on_column & on_dash & visible;
    end
  end

endmodule

// File: src/pong_defines.svh
/* video timing constants: line and frame totals, sync and blanking windows,
   centre net column and dash tap */
`ifndef PONG_DEFINES_SVH
`define PONG_DEFINES_SVH

// horizontal, in pixel clocks
`define H_TOTAL      455  // pixels per line, 0..454
`define HBLANK_END   80   // positions below this are blanked
`define HSYNC_START  32   // hsync window start, inclusive
`define HSYNC_END    64   // hsync window end, exclusive

// vertical, in lines
`define V_TOTAL      262  // lines per frame, 0..261
`define VBLANK_END   16   // lines below this are blanked
`define VSYNC_START  4    // vsync window start, inclusive
`define VSYNC_END    8    // vsync window end, exclusive

// centre net
`define NET_COLUMN   256  // pixel column of the net, the h256 tap
`define NET_DASH_BIT 2    // v4 tap, dashes 4 lines long

// the net column lies in the visible part of the line
// and both sync windows sit inside their blanking ranges
// 32..63 < 80 and 4..7 < 16

`endif

// File: src/pong_pkg.sv
/* counter types shared by the video timing blocks */
package pong_pkg;

  // horizontal pixel position 0..454
  // 9 bits covers the 455 positions of a line
  typedef logic [8:0] hcount_t;

  // vertical line number 0..261
  // 9 bits with bit 8 as the old v256 flop
  typedef logic [8:0] vcount_t;

endpackage

// File: src/pong_video.sv
/* video timing top: counters, sync/blank decode and centre net,
   counts and levels exported as plain ports */
`timescale 1ns/1ps

module pong_video (
  input  logic              hreset,     // pixel clock
  input  logic              vreset,     // sync reset, active high
  output pong_pkg::hcount_t hcnt,       // pixel position, for game blocks
  output pong_pkg::vcount_t vcnt,       // line number, for game blocks
  output logic              frame_end,  // last pixel of frame
  output logic              hsync,
  output logic              vsync,
  output logic              blank,
  output logic              video       // centre net, already blanked
);

  video_timing_if tim ();  // counts and strobes inside the core

  hcounter u_hcounter (
    .hreset (hreset),
    .vreset (vreset),
    .tim    (tim)
  );

  vcounter u_vcounter (
    .hreset (hreset),
    .vreset (vreset),
    .tim    (tim)
  );

  sync_gen u_sync_gen (
    .hreset (hreset),
    .vreset (vreset),
    .tim    (tim),
    .hsync  (hsync),
    .vsync  (vsync),
    .blank  (blank)
  );

  net_gen u_net_gen (
    .hreset (hreset),
    .vreset (vreset),
    .tim    (tim),
    .video  (video)
  );

  // hooks for paddles, ball and score
  assign hcnt      = tim.hcnt;
  assign vcnt      = tim.vcnt;
  assign frame_end = tim.frame_end;

endmodule

// File: src/sync_gen.sv
/* registered horizontal sync, vertical sync and composite blanking
   decoded from the counts, one cycle latency */
`timescale 1ns/1ps
`include "pong_defines.svh"

module sync_gen (
  input  logic            hreset,  // pixel clock
  input  logic            vreset,  // sync reset, active high
  video_timing_if.sink    tim,
  output logic            hsync,
  output logic            vsync,
  output logic            blank
);

  localparam pong_pkg::hcount_t HS_START = pong_pkg::hcount_t'(`HSYNC_START);
  localparam pong_pkg::hcount_t HS_END   = pong_pkg::hcount_t'(`HSYNC_END);
  localparam pong_pkg::hcount_t HB_END   = pong_pkg::hcount_t'(`HBLANK_END);
  localparam pong_pkg::vcount_t VS_START = pong_pkg::vcount_t'(`VSYNC_START);
  localparam pong_pkg::vcount_t VS_END   = pong_pkg::vcount_t'(`VSYNC_END);
  localparam pong_pkg::vcount_t VB_END   = pong_pkg::vcount_t'(`VBLANK_END);

  logic hsync_d;  // inside hsync window
  logic vsync_d;  // inside vsync window
  logic hblank;   // left border of line
  logic vblank;   // top lines of frame

  // half-open windows [start, end)
  assign hsync_d = (tim.hcnt >= HS_START) && (tim.hcnt < HS_END);
  assign vsync_d = (tim.vcnt >= VS_START) && (tim.vcnt < VS_END);
  assign hblank  = (tim.hcnt < HB_END);
  assign vblank  = (tim.vcnt < VB_END);

  always_ff @(posedge hreset) begin
    if (vreset) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      blank <= 1'b0;  // low in reset, not blanked
    end else begin
      hsync <= hsync_d;
      vsync <= vsync_d;
      blank <= hblank | vblank;  // composite blanking
    end
  end

  // sync pulse always falls inside blanking
  a_hsync_blank: assert property (
    @(posedge hreset) disable iff (vreset)
    hsync |-> blank
  );

endmodule

// File: src/vcounter.sv
/* line counter over one frame, stepped by line_end, with end-of-frame strobe */
`timescale 1ns/1ps
`include "pong_defines.svh"

module vcounter (
  input logic             hreset,  // pixel clock
  input logic             vreset,  // sync reset, active high
  video_timing_if.vsrc    tim
);

  localparam pong_pkg::vcount_t V_LAST = pong_pkg::vcount_t'(`V_TOTAL - 1);  // 261
  localparam pong_pkg::vcount_t V_MAX  = pong_pkg::vcount_t'(`V_TOTAL);      // 262

  pong_pkg::vcount_t vcnt_q;    // current line
  logic              last_line; // on line 261

  assign last_line = (vcnt_q == V_LAST);

  // one synchronous compare replaces the ripple chain and the 261 decode flop
  always_ff @(posedge hreset) begin
    if (vreset) begin
      vcnt_q <= '0;
    end else if (tim.line_end) begin          // clock enable from end of line
      if (last_line) begin
        vcnt_q <= '0;                          // wrap 261 -> 0
      end else begin
        vcnt_q <= vcnt_q + pong_pkg::vcount_t'(1);
      end
    end
  end

  assign tim.vcnt      = vcnt_q;
  assign tim.frame_end = tim.line_end & last_line;  // last pixel of frame

  // line number stays inside the frame
  a_vcnt_range: assert property (
    @(posedge hreset) disable iff (vreset)
    vcnt_q < V_MAX
  );

  // line only moves on the end-of-line strobe
  a_vcnt_hold: assert property (
    @(posedge hreset) disable iff (vreset)
    !tim.line_end |=> $stable(tim.vcnt)
  );

  // frame strobe leads back to line 0
  a_frame_wrap: assert property (
    @(posedge hreset) disable iff (vreset)
    tim.frame_end |=> (tim.vcnt == '0)
  );

endmodule

// File: src/video_timing_if.sv
/* counts and line/frame strobes from the counters to the decoders,
   with source and sink modports */
`timescale 1ns/1ps

interface video_timing_if;

  pong_pkg::hcount_t hcnt;       // pixel position in line
  logic              line_end;   // high on last pixel of a line
  pong_pkg::vcount_t vcnt;       // line number in frame
  logic              frame_end;  // high on last pixel of last line

  // horizontal counter owns hcnt and the line strobe
  modport hsrc (
    output hcnt,
    output line_end
  );

  // vertical counter steps on line_end
  modport vsrc (
    input  line_end,
    output vcnt,
    output frame_end
  );

  // decoders read everything
  modport sink (
    input hcnt,
    input line_end,
    input vcnt,
    input frame_end
  );

endinterface

// File: test/tb_pong_video.sv
/* testbench for the video timing core: cycle-count reference model,
   checkpoint table with mid-frame reset, compare tasks and final report */
`timescale 1ns/1ps
`include "pong_defines.svh"

module tb_pong_video;

  localparam int          NSTEP      = 11;
  localparam int unsigned STEP_LIMIT = 200000;  // max cycles per wait

  logic              hreset;     // pixel clock
  logic              vreset;
  pong_pkg::hcount_t hcnt;
  pong_pkg::vcount_t vcnt;
  logic              frame_end;
  logic              hsync;
  logic              vsync;
  logic              blank;
  logic              video;

  int unsigned cyc;              // rising edges since reset release
  int unsigned err_h;
  int unsigned err_v;
  int unsigned err_lvl;
  int unsigned err_to;
  bit          timed_out;

  // checkpoints: target cycle, reset pulse first, hand-derived counts and levels
  int unsigned tgt_tab [NSTEP] = '{0, 33, 455, 1900, 9357, 11177, 119209, 119210,
                                   120675, 0, 16637};
  bit          rst_tab [NSTEP] = '{1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0};
  int unsigned h_tab   [NSTEP] = '{0, 33, 0, 80, 257, 257, 454, 0, 100, 0, 257};
  int unsigned v_tab   [NSTEP] = '{0, 0, 1, 4, 20, 24, 261, 0, 3, 0, 36};
  bit          vid_tab [NSTEP] = '{0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1};
  bit          fe_tab  [NSTEP] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0};
  string       note_tab [NSTEP] = '{"counts at reset release", "inside hsync window",
                                    "first line wrap", "vsync line 4", "net dash line 20",
                                    "no net on line 24", "last pixel of frame",
                                    "frame wrap", "line 3 of second frame",
                                    "mid-frame reset", "net dash line 36 after restart"};

  pong_video DUT (
    .hreset    (hreset),
    .vreset    (vreset),
    .hcnt      (hcnt),
    .vcnt      (vcnt),
    .frame_end (frame_end),
    .hsync     (hsync),
    .vsync     (vsync),
    .blank     (blank),
    .video     (video)
  );

  always #10 hreset = ~hreset;  // 20 ns period

  // expected counts as a pure function of elapsed cycles
  function automatic pong_pkg::hcount_t count_h(input int unsigned n);
    return pong_pkg::hcount_t'(n % `H_TOTAL);
  endfunction

  function automatic pong_pkg::vcount_t count_v(input int unsigned n);
    return pong_pkg::vcount_t'((n / `H_TOTAL) % `V_TOTAL);
  endfunction

  task automatic check_hcount(input pong_pkg::hcount_t got, input pong_pkg::hcount_t exp);
    if (got !== exp) begin
      err_h++;
      $display("** Error at %0t ns: hcnt is %0d, expected %0d (cycle %0d)", $time, got, exp, cyc);
    end
  endtask

  task automatic check_vcount(input pong_pkg::vcount_t got, input pong_pkg::vcount_t exp);
    if (got !== exp) begin
      err_v++;
      $display("** Error at %0t ns: vcnt is %0d, expected %0d (cycle %0d)", $time, got, exp, cyc);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_lvl++;
      $display("** Error at %0t ns: %s is %b, expected %b (cycle %0d)", $time, name, got, exp,
               cyc);
    end
  endtask

  // compare every output with the model, levels decode the previous counts
  task automatic check_all();
    pong_pkg::hcount_t h;
    pong_pkg::vcount_t v;
    pong_pkg::hcount_t ph;
    pong_pkg::vcount_t pv;
    logic              bl;
    h = count_h(cyc);
    v = count_v(cyc);
    check_hcount(hcnt, h);
    check_vcount(vcnt, v);
    check_level("frame_end", frame_end, (h == `H_TOTAL - 1) && (v == `V_TOTAL - 1));
    if (cyc == 0) begin                       // previous edge was still in reset
      check_level("hsync", hsync, 1'b0);
      check_level("vsync", vsync, 1'b0);
      check_level("blank", blank, 1'b0);
      check_level("video", video, 1'b0);
    end else begin
      ph = count_h(cyc - 1);
      pv = count_v(cyc - 1);
      bl = (ph < `HBLANK_END) || (pv < `VBLANK_END);
      check_level("hsync", hsync, (ph >= `HSYNC_START) && (ph < `HSYNC_END));
      check_level("vsync", vsync, (pv >= `VSYNC_START) && (pv < `VSYNC_END));
      check_level("blank", blank, bl);
      check_level("video", video, (ph == `NET_COLUMN) && pv[`NET_DASH_BIT] && !bl);
    end
  endtask

  // called on a falling edge, returns on the falling edge after release
  task automatic pulse_reset();
    vreset = 1'b1;
    repeat (4) @(negedge hreset);  // 4 rising edges in reset
    vreset = 1'b0;
    cyc    = 0;
  endtask

  // step to the target cycle, checking every cycle on the way
  task automatic run_to(input int unsigned target, output bit expired);
    int unsigned guard;
    guard   = 0;
    expired = 1'b0;
    while (cyc < target && !expired) begin
      if (guard >= STEP_LIMIT) begin
        expired = 1'b1;
      end else begin
        @(negedge hreset);  // outputs settled since the rising edge
        cyc++;
        check_all();
        guard++;
      end
    end
  endtask

  initial begin
    hreset    = 1'b0;
    vreset    = 1'b1;
    cyc       = 0;
    err_h     = 0;
    err_v     = 0;
    err_lvl   = 0;
    err_to    = 0;
    timed_out = 1'b0;
    for (int i = 0; i < NSTEP; i++) begin
      if (!timed_out) begin
        if (rst_tab[i]) begin
          pulse_reset();
          check_all();
        end
        run_to(tgt_tab[i], timed_out);
        if (timed_out) begin
          err_to++;
          $display("Timeout: cycle %0d of step '%s' was not reached within %0d cycles",
                   tgt_tab[i], note_tab[i], STEP_LIMIT);
        end else begin
          check_hcount(hcnt, pong_pkg::hcount_t'(h_tab[i]));  // hand-derived spot values
          check_vcount(vcnt, pong_pkg::vcount_t'(v_tab[i]));
          check_level("video", video, vid_tab[i]);
          check_level("frame_end", frame_end, fe_tab[i]);
          $display("[%0t ns] step %0d, %s: hcnt %0d vcnt %0d", $time, i, note_tab[i], hcnt, vcnt);
        end
      end
    end
    $display("errors: hcnt %0d, vcnt %0d, level %0d, timeout %0d", err_h, err_v, err_lvl,
             err_to);
    if (!timed_out && (err_h + err_v + err_lvl) == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
